// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = aguTb
FILELIST = compile.f
OBJDIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: compile.f
+incdir+hdl
hdl/aguPkg.sv
hdl/addrGen.sv
hdl/addrTranslate.sv
hdl/storeFormat.sv
hdl/aguTop.sv
test/aguTb.sv

// File: hdl/addrGen.sv
`timescale 1ns/100ps
`default_nettype none
`include "agu_defines.svh"

module addrGen import aguPkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire issueOp     issue,
    input  wire vmemState   vmem,
    input  wire branchFlush branch,
    input  wire        hold,
    output addrOp      genOp
);

logic                 isAmo;
logic [`AGU_XLEN-1:0] offset;
logic [`AGU_XLEN-1:0] addr;
logic                 misalign;
logic                 killIssue;
logic                 killHeld;
addrOp                nextOp;

assign killIssue = branch.taken && isYounger(issue.sqN, branch.sqN);
assign killHeld  = branch.taken && isYounger(genOp.sqN, branch.sqN);

always_comb begin
    isAmo  = issue.opcode >= OP_AMOSWAP;
    offset = isAmo ? '0 : {{(`AGU_XLEN-12){issue.imm[11]}}, issue.imm}; // AMOs take srcA as is
    addr   = issue.srcA + offset;

    nextOp        = '0;
    nextOp.valid  = issue.valid && !killIssue;
    nextOp.opcode = issue.opcode;
    nextOp.addr   = addr;
    nextOp.srcB   = issue.srcB;
    nextOp.srcC   = issue.srcC;
    nextOp.sqN    = issue.sqN;
    nextOp.tag    = issue.tag;

    case (issue.opcode)
        OP_LB:  begin nextOp.size = 2'd0; nextOp.signExtend = 1'b1; nextOp.isLoad = 1'b1; end
        OP_LH:  begin nextOp.size = 2'd1; nextOp.signExtend = 1'b1; nextOp.isLoad = 1'b1; end
        OP_LW:  begin nextOp.size = 2'd2; nextOp.isLoad = 1'b1; end
        OP_LBU: begin nextOp.size = 2'd0; nextOp.isLoad = 1'b1; end
        OP_LHU: begin nextOp.size = 2'd1; nextOp.isLoad = 1'b1; end
        OP_SB:  begin nextOp.size = 2'd0; nextOp.isStore = 1'b1; end
        OP_SH:  begin nextOp.size = 2'd1; nextOp.isStore = 1'b1; end
        OP_SW:  begin nextOp.size = 2'd2; nextOp.isStore = 1'b1; end
        default: begin
            // Read-modify-write word
            nextOp.size    = 2'd2;
            nextOp.isLoad  = 1'b1;
            nextOp.isStore = 1'b1;
        end
    endcase

    misalign = (nextOp.size == 2'd1 && addr[0]) || (nextOp.size == 2'd2 && addr[1:0] != 2'b00);

    if (misalign)
        nextOp.except = EXC_MISALIGN; // Wins over access fault
    else if (!vmem.sv32en && !`AGU_IS_LEGAL(addr))
        nextOp.except = EXC_ACCESS;
    else
        nextOp.except = EXC_NONE;
end

always_ff @(posedge clk) begin
    if (!hold)
        genOp <= nextOp;
    else if (killHeld)
        genOp.valid <= 1'b0; // Held op flushed behind a walk

    if (rst)
        genOp.valid <= 1'b0;
end

endmodule

`default_nettype wire

// File: hdl/addrTranslate.sv
`timescale 1ns/100ps
`default_nettype none
`include "agu_defines.svh"

module addrTranslate import aguPkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire vmemState   vmem,
    input  wire branchFlush branch,
    input  wire addrOp      genOp,
    output walkRq      walkRequest,
    input  wire walkRes     walkResult,
    output logic       stall,
    output addrOp      xlatOp
);

addrOp                held;  // Pass-through register, or the op under walk
logic                 busy;
logic                 accept;
logic                 needWalk;
logic                 killGen;
logic                 killHeld;
logic [`AGU_XLEN-1:0] physAddr;
logic                 pageFault;
logic                 accFault;

assign killGen  = branch.taken && isYounger(genOp.sqN, branch.sqN);
assign killHeld = branch.taken && isYounger(held.sqN, branch.sqN);

assign accept   = !busy || walkResult.valid;
assign needWalk = genOp.valid && !killGen && vmem.sv32en && genOp.except == EXC_NONE;

// Drops in the cycle the walk result comes back
assign stall = busy && !walkResult.valid;

always_comb begin
    if (walkResult.superPage)
        physAddr = {walkResult.pte.flat.ppn[19:10], held.addr[21:0]};
    else
        physAddr = {walkResult.pte.flat.ppn[19:0], held.addr[11:0]};

    pageFault = 1'b0;
    case ({walkResult.pte.leaf.x, walkResult.pte.leaf.w, walkResult.pte.leaf.r})
        3'b000, 3'b010, 3'b110: pageFault = 1'b1; // Pointer or reserved
        3'b100: if (!vmem.mxr) pageFault = 1'b1;
        default: ;
    endcase

    if (held.isStore && !walkResult.pte.leaf.w)
        pageFault = 1'b1;
    if (!walkResult.pte.leaf.v || !walkResult.pte.leaf.a)
        pageFault = 1'b1;
    if (held.isStore && !walkResult.pte.leaf.d)
        pageFault = 1'b1;
    if (vmem.priv == PRIV_USER && !walkResult.pte.leaf.u)
        pageFault = 1'b1;
    if (vmem.priv == PRIV_SUPERVISOR && walkResult.pte.leaf.u && !vmem.sum)
        pageFault = 1'b1;
    if (walkResult.superPage && walkResult.pte.flat.ppn[9:0] != 10'd0)
        pageFault = 1'b1; // Misaligned superpage

    // Physical page above 32 bits or outside the region
    accFault = walkResult.pte.flat.ppn[21:20] != 2'b00 || !`AGU_IS_LEGAL(physAddr);
end

always_comb begin
    xlatOp = held;
    if (busy) begin
        xlatOp.valid = walkResult.valid && held.valid;
        xlatOp.addr  = physAddr;
        if (accFault)
            xlatOp.except = EXC_ACCESS;
        else if (pageFault)
            xlatOp.except = EXC_PAGE;
        else
            xlatOp.except = EXC_NONE;
    end
end

always_ff @(posedge clk) begin
    walkRequest.valid <= 1'b0;

    if (accept) begin
        held                <= genOp;
        held.valid          <= genOp.valid && !killGen;
        busy                <= needWalk;
        walkRequest.valid   <= needWalk;
        walkRequest.vaddr   <= genOp.addr;
        walkRequest.rootPpn <= vmem.rootPpn;
    end
    else if (killHeld) begin
        held.valid <= 1'b0; // Keep waiting, result is thrown away
    end

    if (rst) begin
        held.valid        <= 1'b0;
        busy              <= 1'b0;
        walkRequest.valid <= 1'b0;
    end
end

endmodule

`default_nettype wire

// File: hdl/aguPkg.sv
`default_nettype none
`include "agu_defines.svh"

package aguPkg;

    typedef enum logic [4:0] {
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_AMOSWAP, OP_AMOADD, OP_AMOXOR, OP_AMOAND, OP_AMOOR,
        OP_AMOMIN, OP_AMOMAX, OP_AMOMINU, OP_AMOMAXU
    } memOpcode;

    typedef enum logic [1:0] {
        EXC_NONE, EXC_MISALIGN, EXC_ACCESS, EXC_PAGE
    } aguExcept;

    typedef enum logic {
        PRIV_USER, PRIV_SUPERVISOR
    } privMode;

    typedef struct packed {
        logic                  valid;
        memOpcode              opcode;
        logic [`AGU_XLEN-1:0]  srcA;
        logic [`AGU_XLEN-1:0]  srcB;
        logic [`AGU_XLEN-1:0]  srcC;
        logic [11:0]           imm;
        logic [`AGU_SQN_W-1:0] sqN;
        logic [6:0]            tag;
    } issueOp;

    typedef struct packed {
        logic        sv32en;
        logic [21:0] rootPpn;
        privMode     priv;
        logic        sum; // Supervisor may touch user pages
        logic        mxr; // Execute-only pages readable
    } vmemState;

    typedef struct packed {
        logic                  valid;
        memOpcode              opcode;
        logic [`AGU_XLEN-1:0]  addr;
        logic [`AGU_XLEN-1:0]  srcB;
        logic [`AGU_XLEN-1:0]  srcC;
        logic [`AGU_SQN_W-1:0] sqN;
        logic [6:0]            tag;
        logic [1:0]            size; // log2 of byte count
        logic                  signExtend;
        logic                  isLoad;
        logic                  isStore;
        aguExcept              except;
    } addrOp;

    typedef struct packed {
        logic                  valid;
        logic [`AGU_XLEN-1:0]  addr;
        logic [`AGU_XLEN-1:0]  data;
        logic [3:0]            wmask;
        logic [1:0]            size;
        logic                  signExtend;
        logic                  isLoad;
        logic                  isStore;
        logic [`AGU_SQN_W-1:0] sqN;
        logic [6:0]            tag;
        aguExcept              except;
    } memOp;

    typedef struct packed {
        logic                 valid;
        logic [`AGU_XLEN-1:0] vaddr;
        logic [21:0]          rootPpn;
    } walkRq;

    // Sv32 leaf entry
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d, a, g, u, x, w, r, v;
    } pteLeaf;

    typedef struct packed {
        logic [21:0] ppn;
        logic [9:0]  flags;
    } pteFlat;

    typedef union packed {
        pteLeaf leaf;
        pteFlat flat;
    } pteWord;

    typedef struct packed {
        logic   valid;
        logic   superPage;
        pteWord pte;
    } walkRes;

    typedef struct packed {
        logic                  taken;
        logic [`AGU_SQN_W-1:0] sqN;
    } branchFlush;

    // True when a is younger than b, tolerant of wrap
    function automatic logic isYounger(input logic [`AGU_SQN_W-1:0] a,
                                       input logic [`AGU_SQN_W-1:0] b);
        logic [`AGU_SQN_W-1:0] diff;
        diff = a - b;
        return !diff[`AGU_SQN_W-1] && (diff != '0);
    endfunction

endpackage

`default_nettype wire

// File: hdl/aguTop.sv
`timescale 1ns/100ps
`default_nettype none

module aguTop import aguPkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire issueOp     issue,
    input  wire vmemState   vmem,
    input  wire branchFlush branch,
    output logic       stall,
    output walkRq      walkRequest,
    input  wire walkRes     walkResult,
    output memOp       result
);

addrOp genOp;
addrOp xlatOp;

addrGen addrGen_i (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .vmem   (vmem),
    .branch (branch),
    .hold   (stall),
    .genOp  (genOp)
);

addrTranslate addrTranslate_i (
    .clk         (clk),
    .rst         (rst),
    .vmem        (vmem),
    .branch      (branch),
    .genOp       (genOp),
    .walkRequest (walkRequest),
    .walkResult  (walkResult),
    .stall       (stall),
    .xlatOp      (xlatOp)
);

storeFormat storeFormat_i (
    .clk    (clk),
    .rst    (rst),
    .branch (branch),
    .xlatOp (xlatOp),
    .result (result)
);

endmodule

`default_nettype wire

// File: hdl/agu_defines.svh
`ifndef AGU_DEFINES_SVH
`define AGU_DEFINES_SVH

// Data and address width
`define AGU_XLEN 32

// Sequence number width, wraps around
`define AGU_SQN_W 7

// Physical region open to loads and stores
`define AGU_LEGAL_LO 32'h8000_0000
`define AGU_LEGAL_HI 32'h8FFF_FFFF

`define AGU_IS_LEGAL(a) (((a) >= `AGU_LEGAL_LO) && ((a) <= `AGU_LEGAL_HI))

`endif

// File: hdl/storeFormat.sv
`timescale 1ns/100ps
`default_nettype none
`include "agu_defines.svh"

module storeFormat import aguPkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire branchFlush branch,
    input  wire addrOp      xlatOp,
    output memOp       result
);

logic                 kill;
logic [3:0]           wmask;
logic [`AGU_XLEN-1:0] wdata;
logic                 bLess;
logic                 bLessU;

assign kill   = branch.taken && isYounger(xlatOp.sqN, branch.sqN);
assign bLess  = $signed(xlatOp.srcB) < $signed(xlatOp.srcC);
assign bLessU = xlatOp.srcB < xlatOp.srcC;

always_comb begin
    wmask = 4'b0000;
    wdata = '0;
    if (xlatOp.isStore && xlatOp.except == EXC_NONE) begin
        if (xlatOp.isLoad) begin
            wmask = 4'b1111; // AMO always writes the full word
            case (xlatOp.opcode)
                OP_AMOADD:  wdata = xlatOp.srcB + xlatOp.srcC;
                OP_AMOXOR:  wdata = xlatOp.srcB ^ xlatOp.srcC;
                OP_AMOAND:  wdata = xlatOp.srcB & xlatOp.srcC;
                OP_AMOOR:   wdata = xlatOp.srcB | xlatOp.srcC;
                OP_AMOMIN:  wdata = bLess ? xlatOp.srcB : xlatOp.srcC;
                OP_AMOMAX:  wdata = bLess ? xlatOp.srcC : xlatOp.srcB;
                OP_AMOMINU: wdata = bLessU ? xlatOp.srcB : xlatOp.srcC;
                OP_AMOMAXU: wdata = bLessU ? xlatOp.srcC : xlatOp.srcB;
                default:    wdata = xlatOp.srcB; // Swap
            endcase
        end
        else begin
            case (xlatOp.size)
                2'd0: begin
                    wmask = 4'b0001 << xlatOp.addr[1:0];
                    wdata = xlatOp.srcB << {xlatOp.addr[1:0], 3'b000};
                end
                2'd1: begin
                    wmask = 4'b0011 << {xlatOp.addr[1], 1'b0};
                    wdata = xlatOp.srcB << {xlatOp.addr[1], 4'b0000};
                end
                default: begin
                    wmask = 4'b1111;
                    wdata = xlatOp.srcB;
                end
            endcase
        end
    end
end

always_ff @(posedge clk) begin
    result.valid      <= xlatOp.valid && !kill;
    result.addr       <= xlatOp.addr;
    result.data       <= wdata;
    result.wmask      <= wmask;
    result.size       <= xlatOp.size;
    result.signExtend <= xlatOp.signExtend;
    result.isLoad     <= xlatOp.isLoad;
    result.isStore    <= xlatOp.isStore;
    result.sqN        <= xlatOp.sqN;
    result.tag        <= xlatOp.tag;
    result.except     <= xlatOp.except;
    if (rst)
        result.valid <= 1'b0;
end

endmodule

`default_nettype wire

// File: test/aguTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "agu_defines.svh"

module aguTb import aguPkg::*; ();

logic       clk = 1'b0;
logic       rst = 1'b1;
issueOp     issue;
vmemState   vmem;
branchFlush branch;
logic       stall;
walkRq      walkRequest;
walkRes     walkResult;
memOp       result;

logic [31:0] lfsr = 32'd96;
int          cyc = 0;
int          respCyc = 0;
int          reqCount = 0;
int          respCount = 0;
int          pending = 0;
logic        walkActive = 1'b0;
walkRq       lastReq;
pteWord      walkPte;
logic        walkSuper;

aguTop dut_i (
    .clk(clk), .rst(rst), .issue(issue), .vmem(vmem), .branch(branch), .stall(stall),
    .walkRequest(walkRequest), .walkResult(walkResult), .result(result)
);

always #10 clk = ~clk;
always @(posedge clk) cyc <= cyc + 1;

task automatic abortRun(input string msg);
    $display("%s at t=%0t", msg, $time);
    $display("sim failed");
    $fatal(1);
endtask

task automatic checkMemOp(input string name, input memOp exp, input memOp got);
    if (got !== exp) begin
        $display("error t=%0t %s expected %h got %h", $time, name, exp, got);
        $display("sim failed");
        $fatal(1);
    end
endtask

task automatic checkExcept(input string name, input aguExcept exp, input aguExcept got);
    if (got !== exp) begin
        $display("error t=%0t %s expected %s got %s", $time, name, exp.name(), got.name());
        $display("sim failed");
        $fatal(1);
    end
endtask

task automatic checkWalkRq(input string name, input walkRq exp, input walkRq got);
    if (got !== exp) begin
        $display("error t=%0t %s expected %h got %h", $time, name, exp, got);
        $display("sim failed");
        $fatal(1);
    end
endtask

task automatic checkFlag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
        $display("error t=%0t %s expected %b got %b", $time, name, exp, got);
        $display("sim failed");
        $fatal(1);
    end
endtask

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] randBits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits = {bits[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
    end
    return bits;
endfunction

// Request capture and stall watch
always @(posedge clk) begin
    #1;
    if (!rst && walkRequest.valid) begin
        lastReq = walkRequest;
        reqCount++;
        pending++;
        walkActive = 1'b1;
    end
    if (!rst)
        checkFlag("stall", walkActive, stall);
end

// Walker model answering 1 to 8 cycles after the request
always begin
    int d;
    @(posedge clk);
    #2;
    if (pending > 0) begin
        pending--;
        d = 1 + randBits(3);
        repeat (d) @(posedge clk);
        #2;
        walkResult.valid     = 1'b1;
        walkResult.superPage = walkSuper;
        walkResult.pte       = walkPte;
        walkActive = 1'b0;
        respCyc = cyc;
        respCount++;
        @(posedge clk);
        #2 walkResult.valid = 1'b0;
    end
end

function automatic logic inRegion(input logic [31:0] a);
    return a >= `AGU_LEGAL_LO && a <= `AGU_LEGAL_HI;
endfunction

function automatic logic [31:0] effAddr(input memOpcode opc, input logic [31:0] a,
                                        input logic [11:0] imm);
    return (opc >= OP_AMOSWAP) ? a : a + {{20{imm[11]}}, imm};
endfunction

function automatic logic [1:0] accessSize(input memOpcode opc);
    if (opc == OP_LB || opc == OP_LBU || opc == OP_SB)
        return 2'd0;
    if (opc == OP_LH || opc == OP_LHU || opc == OP_SH)
        return 2'd1;
    return 2'd2;
endfunction

function automatic logic misaligned(input logic [31:0] va, input logic [1:0] sz);
    return (va & ((32'd1 << sz) - 32'd1)) != 32'd0; // Any byte offset below the access size
endfunction

// Reference model of the whole pipeline
function automatic memOp modelOp(input memOpcode opc, input logic [31:0] a, b, c,
                                 input logic [11:0] imm, input logic [6:0] sqN);
    memOp   m;
    pteLeaf p;
    logic   pf;
    logic   amo;
    m = '0;
    amo = opc >= OP_AMOSWAP;
    p = walkPte.leaf;
    m.valid = 1'b1;
    m.addr = effAddr(opc, a, imm);
    m.size = accessSize(opc);
    m.signExtend = opc == OP_LB || opc == OP_LH;
    m.isLoad = opc <= OP_LHU || amo;
    m.isStore = opc >= OP_SB;
    m.sqN = sqN;
    m.tag = sqN ^ 7'h55;
    if (misaligned(m.addr, m.size))
        m.except = EXC_MISALIGN;
    else if (!vmem.sv32en && !inRegion(m.addr))
        m.except = EXC_ACCESS;
    else if (vmem.sv32en) begin
        m.addr = walkSuper ? {walkPte.flat.ppn[19:10], m.addr[21:0]}
                           : {walkPte.flat.ppn[19:0], m.addr[11:0]};
        pf = !p.v || !p.a || (!p.r && p.w) || (!p.r && !p.w && !p.x)
            || (p.x && !p.r && !p.w && !vmem.mxr) || (m.isStore && (!p.w || !p.d))
            || (vmem.priv == PRIV_USER && !p.u)
            || (vmem.priv == PRIV_SUPERVISOR && p.u && !vmem.sum)
            || (walkSuper && walkPte.flat.ppn[9:0] != 10'd0);
        if (walkPte.flat.ppn[21:20] != 2'b00 || !inRegion(m.addr))
            m.except = EXC_ACCESS;
        else if (pf)
            m.except = EXC_PAGE;
    end
    if (m.except == EXC_NONE && m.isStore) begin
        if (amo) begin
            m.wmask = 4'hF;
            case (opc)
                OP_AMOADD:  m.data = b + c;
                OP_AMOXOR:  m.data = b ^ c;
                OP_AMOAND:  m.data = b & c;
                OP_AMOOR:   m.data = b | c;
                OP_AMOMIN:  m.data = ($signed(b) < $signed(c)) ? b : c;
                OP_AMOMAX:  m.data = ($signed(b) > $signed(c)) ? b : c;
                OP_AMOMINU: m.data = (b < c) ? b : c;
                OP_AMOMAXU: m.data = (b > c) ? b : c;
                default:    m.data = b;
            endcase
        end
        else begin
            for (int i = 0; i < 4; i++)
                m.wmask[i] = i >= m.addr[1:0] && i < m.addr[1:0] + (1 << m.size);
            m.data = b << (8 * m.addr[1:0]);
        end
    end
    return m;
endfunction

task automatic tick();
    @(posedge clk);
    #2;
endtask

task automatic sendOp(input memOpcode opc, input logic [31:0] a, b, c,
                      input logic [11:0] imm, input logic [6:0] sqN);
    issue = {1'b1, opc, a, b, c, imm, sqN, sqN ^ 7'h55};
endtask

task automatic waitResult(inout int n);
    int limit;
    limit = n + 40;
    while (!result.valid) begin
        tick();
        n++;
        if (n > limit)
            abortRun("no result arrived within the timeout");
    end
endtask

task automatic runOp(input memOpcode opc, input logic [31:0] a, b, c,
                     input logic [11:0] imm, input logic [6:0] sqN);
    memOp exp;
    int   n;
    int   oldReq;
    logic walks;
    exp = modelOp(opc, a, b, c, imm, sqN);
    walks = vmem.sv32en && !misaligned(effAddr(opc, a, imm), accessSize(opc));
    oldReq = reqCount;
    sendOp(opc, a, b, c, imm, sqN);
    tick();
    issue.valid = 1'b0;
    n = 1;
    waitResult(n);
    if (walks) begin
        if (reqCount != oldReq + 1)
            abortRun("walk request count is wrong");
        checkWalkRq("walkRequest", {1'b1, effAddr(opc, a, imm), vmem.rootPpn}, lastReq);
        if (cyc != respCyc + 1)
            abortRun("translated result not one cycle after the walk response");
    end
    else if (n != 3)
        abortRun($sformatf("result took %0d cycles instead of 3", n));
    checkExcept("result.except", exp.except, result.except);
    checkMemOp("result", exp, result);
endtask

task automatic expectQuiet(input int cycles);
    repeat (cycles) begin
        tick();
        if (result.valid)
            abortRun("a flushed op reached the result port");
    end
endtask

task automatic loadSizes();
    memOpcode    ops [5] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    logic [11:0] imm;
    logic [31:0] base;
    for (int i = 0; i < 20; i++) begin
        imm = randBits(12);
        base = 32'h8010_0000 + randBits(16);
        base = base - ((base + {{20{imm[11]}}, imm}) & 32'h3); // Word aligned target
        runOp(ops[i % 5], base, randBits(32), 0, imm, 7'(i));
    end
endtask

task automatic exceptsWithoutXlat();
    runOp(OP_LH, 32'h0000_1001, 0, 0, 12'h000, 7'd30);
    runOp(OP_LW, 32'h8000_0002, 0, 0, 12'h000, 7'd31);
    runOp(OP_SW, 32'h0000_1001, 32'h1234_5678, 0, 12'h001, 7'd32);
    runOp(OP_LW, 32'h0000_1000, 0, 0, 12'h000, 7'd33);
    runOp(OP_SB, 32'h9000_0000, 32'h55, 0, 12'h003, 7'd34);
endtask

task automatic storeLanes();
    for (int off = 0; off < 4; off++) begin
        runOp(OP_SB, 32'h8000_4000 + off, randBits(32), 0, 12'h000, 7'd40);
        runOp(OP_SH, 32'h8000_4000, randBits(32), 0, 12'(off), 7'd41);
        runOp(OP_SW, 32'h8000_4000 + off, randBits(32), 0, 12'h000, 7'd42);
    end
    for (int opc = OP_AMOSWAP; opc <= OP_AMOMAXU; opc++)
        runOp(memOpcode'(opc), 32'h8000_8000, randBits(32), randBits(32), randBits(12), 7'd43);
endtask

task automatic sv32Walks();
    vmem = {1'b1, 22'(randBits(22)), PRIV_SUPERVISOR, 1'b0, 1'b0};
    walkSuper = 1'b0;
    walkPte = {22'h08_0123, 10'h0C7};
    runOp(OP_LW, 32'h1234_5678, 0, 0, 12'h004, 7'd50);
    runOp(OP_SH, 32'h4000_0ABC, randBits(32), 0, 12'h002, 7'd51);
    walkPte = {22'h08_0123, 10'h043}; // Read only
    runOp(OP_SW, 32'h4000_0100, 32'hDEAD_BEEF, 0, 12'h000, 7'd52);
    walkPte = {22'h08_0123, 10'h0D7}; // User page without sum
    runOp(OP_LW, 32'h4000_0100, 0, 0, 12'h000, 7'd53);
    walkPte = {22'h08_0123, 10'h047}; // Dirty clear
    runOp(OP_SB, 32'h4000_0101, 32'h77, 0, 12'h000, 7'd54);
    walkPte = {22'h00_0123, 10'h0C7}; // Outside region
    runOp(OP_LW, 32'h4000_0100, 0, 0, 12'h000, 7'd55);
    walkSuper = 1'b1;
    walkPte = {22'h08_0001, 10'h0C7}; // Low ppn nonzero
    runOp(OP_LW, 32'h4012_3450, 0, 0, 12'h000, 7'd56);
    walkPte = {22'h08_0400, 10'h0C7};
    runOp(OP_LW, 32'h4012_3450, 0, 0, 12'h000, 7'd57);
    walkSuper = 1'b0;
endtask

task automatic branchFlushes();
    memOp expA;
    memOp expB;
    int   n;
    int   old;
    vmem.sv32en = 1'b0;
    for (int k = 0; k < 3; k++) begin
        sendOp(OP_LW, 32'h8000_0010, 0, 0, 12'h000, 7'd20);
        if (k == 0)
            branch = {1'b1, 7'd10};
        for (int j = 1; j <= 8; j++) begin
            tick();
            issue.valid = 1'b0;
            branch = (j == k) ? {1'b1, 7'd10} : '0;
            if (result.valid)
                abortRun("a flushed op reached the result port");
        end
    end
    // Older op in flight survives the flush
    expA = modelOp(OP_LW, 32'h8000_0020, 0, 0, 12'h000, 7'd8);
    sendOp(OP_LW, 32'h8000_0020, 0, 0, 12'h000, 7'd8);
    tick();
    sendOp(OP_LW, 32'h8000_0030, 0, 0, 12'h000, 7'd20);
    tick();
    issue.valid = 1'b0;
    branch = {1'b1, 7'd10};
    tick();
    branch = '0;
    checkMemOp("result", expA, result);
    expectQuiet(5);
    // Kill during a walk
    vmem.sv32en = 1'b1;
    walkPte = {22'h08_0123, 10'h0C7};
    old = reqCount;
    sendOp(OP_LW, 32'h4000_0200, 0, 0, 12'h000, 7'd70);
    tick();
    issue.valid = 1'b0;
    n = 0;
    while (reqCount == old) begin
        tick();
        n++;
        if (n > 10)
            abortRun("walk request never came");
    end
    old = respCount;
    branch = {1'b1, 7'd65};
    tick();
    branch = '0;
    n = 0;
    while (respCount == old) begin
        tick();
        if (result.valid)
            abortRun("op flushed during a walk reached the result port");
        n++;
        if (n > 20)
            abortRun("walk response never came");
    end
    expectQuiet(3);
    // Op held behind a walk is delivered afterwards
    expA = modelOp(OP_LW, 32'h4000_0300, 0, 0, 12'h000, 7'd80);
    expB = modelOp(OP_LW, 32'h4000_0302, 0, 0, 12'h000, 7'd81);
    sendOp(OP_LW, 32'h4000_0300, 0, 0, 12'h000, 7'd80);
    tick();
    sendOp(OP_LW, 32'h4000_0302, 0, 0, 12'h000, 7'd81);
    tick();
    issue.valid = 1'b0;
    n = 2;
    waitResult(n);
    checkMemOp("result", expA, result);
    tick();
    checkMemOp("result", expB, result);
    if (cyc != respCyc + 2)
        abortRun("held op not delivered right after the walk");
endtask

initial begin
    issue = '0;
    vmem = '0;
    branch = '0;
    walkResult = '0;
    walkPte = '0;
    walkSuper = 1'b0;
    repeat (5) @(posedge clk);
    #2 rst = 1'b0;
    checkFlag("result.valid", 1'b0, result.valid);
    checkFlag("walkRequest.valid", 1'b0, walkRequest.valid);
    checkFlag("stall", 1'b0, stall);
    loadSizes();
    exceptsWithoutXlat();
    storeLanes();
    sv32Walks();
    branchFlushes();
    $display("sim passed");
    $finish;
end

endmodule

`default_nettype wire
